// File: build.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/bus_pkg.sv
verilog/way_ram.sv
verilog/line_state.sv
verilog/word_merge.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/mem_model.sv
sim/dcache_tb.sv

// File: sim/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_tb;

    localparam int unsigned n_vecs     = 19;
    localparam int unsigned n_random   = 200;
    localparam int unsigned max_cycles = (n_vecs + n_random) * 40;
    localparam int unsigned n_words    = 4096;          // Same window as the memory

    typedef struct packed {
        logic              we;
        bus_pkg::byte_en_t be;
        bus_pkg::word_t    addr;
        bus_pkg::word_t    wdata;
        bus_pkg::word_t    rdata;                       // Expected load data
        bus_pkg::word_t    wb_addr;                     // Expected write-back, 0 for none
    } vec_t;

    logic              clk, rst, req_valid, req_ready, rsp_valid;
    logic              mem_req_valid, mem_req_ready, mem_rsp_valid;
    bus_pkg::cpu_req_t req;
    bus_pkg::cpu_rsp_t rsp;
    bus_pkg::mem_req_t mem_req;
    bus_pkg::mem_rsp_t mem_rsp;
    int unsigned       mem_wr_count;
    bus_pkg::word_t    mem_wr_addr;
    dcache_pkg::line_t mem_wr_line;

    vec_t           vecs [n_vecs];
    bus_pkg::word_t ref_mem [n_words];                  // Reference word image
    logic [31:0]    lcg_state;
    int unsigned    data_errs = 0;
    int unsigned    proto_errs = 0;
    int unsigned    cycles = 0;
    int unsigned    accepted = 0;
    int unsigned    responses = 0;

    dcache_top dut (
        .clk_i(clk), .rst_i(rst), .req_valid_i(req_valid), .req_ready_o(req_ready),
        .req_i(req), .rsp_valid_o(rsp_valid), .rsp_o(rsp),
        .mem_req_valid_o(mem_req_valid), .mem_req_o(mem_req), .mem_req_ready_i(mem_req_ready),
        .mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_i(mem_rsp)
    );

    mem_model u_mem (
        .clk_i(clk), .rst_i(rst), .req_valid_i(mem_req_valid), .req_i(mem_req),
        .req_ready_o(mem_req_ready), .rsp_valid_o(mem_rsp_valid), .rsp_o(mem_rsp),
        .wr_count_o(mem_wr_count), .last_wr_addr_o(mem_wr_addr), .last_wr_line_o(mem_wr_line)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Handshake counts and run limit
    always @(posedge clk)
    begin
        cycles++;
        if (!rst && req_valid && req_ready)
            accepted++;
        if (!rst && rsp_valid)
            responses++;
        if (cycles >= max_cycles)
        begin
            $display("Timeout after %0d cycles, the cache stopped responding", cycles);
            $display("Errors: data %0d, protocol %0d", data_errs, proto_errs);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic ref_store(input bus_pkg::word_t addr, input bus_pkg::byte_en_t be,
                             input bus_pkg::word_t wdata);
        for (int b = 0; b < `DC_XLEN / 8; b++)
            if (be[b])
                ref_mem[addr[13:2]][b*8 +: 8] = wdata[b*8 +: 8]; // Enabled lanes only
    endtask

    // Called 1 ns after an edge, returns 1 ns after the edge that ends the response
    task automatic run_request(input bus_pkg::cpu_req_t r, output bus_pkg::word_t rdata);
        req       = r;
        req_valid = 1'b1;
        while (!req_ready)
        begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);                                 // Accepted here
        #1;
        req_valid = 1'b0;
        while (!rsp_valid)
        begin
            @(posedge clk);
            #1;
        end
        rdata = rsp.rdata;
        @(posedge clk);
        #1;
        assert (!rsp_valid)
        else
        begin
            $display("Response for %h stayed valid longer than one cycle", r.addr);
            proto_errs++;
        end
    endtask

    task automatic check_load(input bus_pkg::word_t addr, input bus_pkg::word_t exp,
                              input bus_pkg::word_t got);
        assert (got === exp)
        else
        begin
            $display("Fail t=%0t rsp_o.rdata @%h expected %h got %h", $time, addr, exp, got);
            data_errs++;
        end
    endtask

    task automatic check_write_back(input bus_pkg::word_t wb_addr, input int unsigned n);
        dcache_pkg::word_ofs_t wb_ofs;                  // Word of the stored data in the line
        bus_pkg::word_t        wb_word;
        wb_ofs  = wb_addr[`DC_BYTE_OFS_BITS +: `DC_WORD_OFS_BITS];
        wb_word = mem_wr_line[wb_ofs * `DC_XLEN +: `DC_XLEN];
        assert (n == ((wb_addr == 0) ? 0 : 1))
        else
        begin
            $display("Fail t=%0t mem_req_o write count expected %0d got %0d",
                     $time, (wb_addr == 0) ? 0 : 1, n);
            proto_errs++;
        end
        if (wb_addr != 0)
        begin
            assert (mem_wr_addr === wb_addr)
            else
            begin
                $display("Fail t=%0t mem_req_o.addr expected %h got %h",
                         $time, wb_addr, mem_wr_addr);
                data_errs++;
            end
            assert (wb_word === ref_mem[wb_addr[13:2]])
            else
            begin
                $display("Fail t=%0t mem_req_o.data expected %h got %h", $time,
                         ref_mem[wb_addr[13:2]], wb_word);
                data_errs++;
            end
        end
    endtask

    // we, be, addr, store data, expected load, expected write-back address
    task automatic load_vectors();
        vecs[0]  = '{1'b0, 4'b0000, 32'h0000_0104, 32'h0, 32'hA5A5_0104, 32'h0}; // Cold miss
        vecs[1]  = '{1'b0, 4'b0000, 32'h0000_0104, 32'h0, 32'hA5A5_0104, 32'h0};
        vecs[2]  = '{1'b1, 4'b1111, 32'h0000_0108, 32'hDEAD_BEEF, 32'h0, 32'h0};
        vecs[3]  = '{1'b0, 4'b0000, 32'h0000_0108, 32'h0, 32'hDEAD_BEEF, 32'h0};
        vecs[4]  = '{1'b0, 4'b0000, 32'h0000_010C, 32'h0, 32'hA5A5_010C, 32'h0}; // Neighbour
        vecs[5]  = '{1'b1, 4'b0001, 32'h0000_0104, 32'h1122_3344, 32'h0, 32'h0};
        vecs[6]  = '{1'b0, 4'b0000, 32'h0000_0104, 32'h0, 32'hA5A5_0144, 32'h0};
        vecs[7]  = '{1'b1, 4'b0010, 32'h0000_0104, 32'h5566_7788, 32'h0, 32'h0};
        vecs[8]  = '{1'b0, 4'b0000, 32'h0000_0104, 32'h0, 32'hA5A5_7744, 32'h0};
        vecs[9]  = '{1'b1, 4'b1100, 32'h0000_0214, 32'hCAFE_0000, 32'h0, 32'h0}; // Store miss
        vecs[10] = '{1'b0, 4'b0000, 32'h0000_0214, 32'h0, 32'hCAFE_0214, 32'h0};
        vecs[11] = '{1'b1, 4'b0110, 32'h0000_0328, 32'h00AB_CD00, 32'h0, 32'h0};
        vecs[12] = '{1'b0, 4'b0000, 32'h0000_0328, 32'h0, 32'hA5AB_CD28, 32'h0};
        vecs[13] = '{1'b1, 4'b1111, 32'h0000_1050, 32'h1234_5678, 32'h0, 32'h0}; // Set 5 fills
        vecs[14] = '{1'b0, 4'b0000, 32'h0000_1150, 32'h0, 32'hA5A5_1150, 32'h0};
        vecs[15] = '{1'b0, 4'b0000, 32'h0000_1250, 32'h0, 32'hA5A5_1250, 32'h0};
        vecs[16] = '{1'b0, 4'b0000, 32'h0000_1350, 32'h0, 32'hA5A5_1350, 32'h0};
        vecs[17] = '{1'b0, 4'b0000, 32'h0000_1454, 32'h0, 32'hA5A5_1454, 32'h0000_1050};
        vecs[18] = '{1'b0, 4'b0000, 32'h0000_1050, 32'h0, 32'h1234_5678, 32'h0}; // Evicted line
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial
    begin
        bus_pkg::cpu_req_t r;
        bus_pkg::word_t    got;
        int unsigned       wb_before;
        logic [31:0]       rnd;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        lcg_state = 32'h2585_84c2;
        for (int i = 0; i < n_words; i++)
            ref_mem[i] = (i * 4) ^ 32'hA5A5_0000;
        load_vectors();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (req_ready && !rsp_valid && !mem_req_valid)
        else
        begin
            $display("Cache handshake outputs not at their idle values after reset");
            proto_errs++;
        end

        for (int i = 0; i < n_vecs; i++)
        begin
            r         = '{we: vecs[i].we, be: vecs[i].be, addr: vecs[i].addr,
                          wdata: vecs[i].wdata};
            wb_before = mem_wr_count;
            run_request(r, got);
            if (r.we)
                ref_store(r.addr, r.be, r.wdata);
            else
                check_load(r.addr, vecs[i].rdata, got);
            check_write_back(vecs[i].wb_addr, mem_wr_count - wb_before);
        end

        // Sets 8 to 10, eight tags each, so lines get evicted
        for (int n = 0; n < n_random; n++)
        begin
            rnd     = lcg_next();
            r.we    = rnd[31];
            r.be    = (rnd[27:24] == 4'h0) ? 4'hF : rnd[27:24];
            r.addr  = {24'(rnd[18:16]), 4'(8 + rnd[15:8] % 3), rnd[21:20], 2'b00};
            r.wdata = lcg_next();
            run_request(r, got);
            if (r.we)
                ref_store(r.addr, r.be, r.wdata);
            else
                check_load(r.addr, ref_mem[r.addr[13:2]], got);
        end

        assert (accepted == responses)
        else
        begin
            $display("Saw %0d responses for %0d accepted requests", responses, accepted);
            proto_errs++;
        end
        $display("Errors: data %0d, protocol %0d", data_errs, proto_errs);
        if (data_errs == 0 && proto_errs == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: sim/mem_model.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

// Line-wide memory with fixed handshake delays and a write-back log
module mem_model #(
    parameter int unsigned accept_delay = 2,           // Cycles a request waits before ready
    parameter int unsigned rsp_delay    = 3,           // Read acceptance to data
    parameter int unsigned n_words      = 4096         // 16 KB word window
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_valid_i,
    input  bus_pkg::mem_req_t req_i,
    output logic              req_ready_o,
    output logic              rsp_valid_o,
    output bus_pkg::mem_rsp_t rsp_o,
    output int unsigned       wr_count_o,              // Write-backs seen so far
    output bus_pkg::word_t    last_wr_addr_o,
    output dcache_pkg::line_t last_wr_line_o
);

    localparam int unsigned words_per_line = `DC_LINE_BITS / `DC_XLEN;

    bus_pkg::word_t words [n_words];
    int unsigned    wait_q;                            // Cycles the current request has waited
    int unsigned    delay_q;                           // Read data countdown
    bus_pkg::word_t rd_addr_q;

    // First word of the line holding addr
    function automatic int unsigned line_base(input bus_pkg::word_t addr);
        return ((addr / 4) % n_words) & ~(words_per_line - 1);
    endfunction

    initial
    begin
        for (int i = 0; i < n_words; i++)
            words[i] = (i * 4) ^ 32'hA5A5_0000;        // Byte address XOR fixed mask
    end

    assign req_ready_o = req_valid_i && (wait_q >= accept_delay) && (delay_q == 0);

    always @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wait_q      <= 0;
            delay_q     <= 0;
            rsp_valid_o <= 1'b0;
            wr_count_o  <= 0;
        end
        else
        begin
            rsp_valid_o <= 1'b0;
            wait_q      <= (req_valid_i && !req_ready_o) ? wait_q + 1 : 0;
            if (delay_q != 0)
            begin
                delay_q <= delay_q - 1;
                if (delay_q == 1)
                begin
                    rsp_valid_o <= 1'b1;               // One-cycle data pulse
                    for (int k = 0; k < words_per_line; k++)
                        rsp_o.data[k*`DC_XLEN +: `DC_XLEN] <= words[line_base(rd_addr_q) + k];
                end
            end
            if (req_valid_i && req_ready_o)
            begin
                if (req_i.we)
                begin
                    for (int k = 0; k < words_per_line; k++)
                        words[line_base(req_i.addr) + k] <= req_i.data[k*`DC_XLEN +: `DC_XLEN];
                    wr_count_o     <= wr_count_o + 1;  // Log the write-back
                    last_wr_addr_o <= req_i.addr;
                    last_wr_line_o <= req_i.data;
                end
                else
                begin
                    rd_addr_q <= req_i.addr;
                    delay_q   <= rsp_delay;
                end
            end
        end
    end

endmodule

// File: verilog/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_top (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  bus_pkg::cpu_req_t req_i,
    output logic              rsp_valid_o,
    output bus_pkg::cpu_rsp_t rsp_o,
    output logic              mem_req_valid_o,
    output bus_pkg::mem_req_t mem_req_o,
    input  logic              mem_req_ready_i,
    input  logic              mem_rsp_valid_i,
    input  bus_pkg::mem_rsp_t mem_rsp_i
);

    localparam int unsigned lo_bits = `DC_WORD_OFS_BITS + `DC_BYTE_OFS_BITS;

    bus_pkg::cpu_req_t                       req_q;    // Request in flight
    logic                                    start;
    dcache_pkg::set_idx_t                    set_idx;
    dcache_pkg::tag_t                        req_tag;
    dcache_pkg::word_ofs_t                   word_ofs;
    bus_pkg::byte_en_t                       store_be; // Zero for loads
    dcache_pkg::line_t                       way_line [`DC_N_WAYS];
    dcache_pkg::tag_t                        way_tag  [`DC_N_WAYS];
    dcache_pkg::way_state_t [`DC_N_WAYS-1:0] way_state;
    dcache_pkg::way_mask_t                   way_hit, data_we, tag_we;
    dcache_pkg::way_sel_t                    hit_way, victim;
    dcache_pkg::line_t                       sel_line, hit_line_new;
    dcache_pkg::line_t                       refill_line, refill_line_new, wr_line;
    bus_pkg::word_t                          hit_word, refill_word;
    logic                                    hit, use_refill, fill, mark_dirty;

    // ========================================
    // Request capture and address fields
    // ========================================
    assign start = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i)
    begin
        if (start)
            req_q <= req_i;
    end

    // RAMs see the new set at acceptance so data is ready in lookup
    assign set_idx  = start ? req_i.addr[lo_bits +: `DC_SET_BITS]
                            : req_q.addr[lo_bits +: `DC_SET_BITS];
    assign req_tag  = req_q.addr[`DC_XLEN-1 -: `DC_TAG_BITS];
    assign word_ofs = req_q.addr[`DC_BYTE_OFS_BITS +: `DC_WORD_OFS_BITS];
    assign store_be = req_q.we ? req_q.be : '0;        // Read refill passes unchanged

    // ========================================
    // Data and tag ways
    // ========================================
    for (genvar w = 0; w < `DC_N_WAYS; w++)
    begin : g_way
        way_ram #(.entry_t(dcache_pkg::line_t)) u_data (
            .clk_i(clk_i), .we_i(data_we[w]), .addr_i(set_idx),
            .data_i(wr_line), .data_o(way_line[w])
        );
        way_ram #(.entry_t(dcache_pkg::tag_t)) u_tag (
            .clk_i(clk_i), .we_i(tag_we[w]), .addr_i(set_idx),
            .data_i(req_tag), .data_o(way_tag[w])
        );
    end

    line_state u_state (
        .clk_i(clk_i), .rst_i(rst_i), .set_i(set_idx),
        .state_o(way_state), .victim_o(victim),
        .fill_i(fill), .fill_way_i(victim), .fill_dirty_i(req_q.we),
        .mark_dirty_i(mark_dirty), .hit_way_i(hit_way)
    );

    // Tag compare, at most one way matches
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `DC_N_WAYS; w++)
        begin
            way_hit[w] = way_state[w].valid && (way_tag[w] == req_tag);
            if (way_hit[w])
                hit_way = dcache_pkg::way_sel_t'(w);
        end
    end

    assign hit      = |way_hit;
    assign sel_line = hit ? way_line[hit_way] : way_line[victim]; // Victim on a miss

    // ========================================
    // Store merge and load word
    // ========================================
    word_merge u_hit_merge (
        .line_i(sel_line), .word_ofs_i(word_ofs), .be_i(store_be),
        .wdata_i(req_q.wdata), .word_o(hit_word), .line_o(hit_line_new)
    );

    word_merge u_refill_merge (
        .line_i(refill_line), .word_ofs_i(word_ofs), .be_i(store_be),
        .wdata_i(req_q.wdata), .word_o(refill_word), .line_o(refill_line_new)
    );

    assign wr_line     = use_refill ? refill_line_new : hit_line_new;
    assign rsp_o.rdata = use_refill ? refill_word : hit_word;

    dcache_ctrl u_ctrl (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start), .is_write_i(req_q.we),
        .hit_i(hit), .hit_way_i(hit_way), .victim_i(victim),
        .victim_dirty_i(way_state[victim].dirty), .victim_tag_i(way_tag[victim]),
        .victim_line_i(sel_line), .req_addr_i(req_q.addr),
        .mem_req_valid_o(mem_req_valid_o), .mem_req_o(mem_req_o),
        .mem_req_ready_i(mem_req_ready_i), .mem_rsp_valid_i(mem_rsp_valid_i),
        .mem_rsp_i(mem_rsp_i), .refill_line_o(refill_line),
        .req_ready_o(req_ready_o), .rsp_valid_o(rsp_valid_o),
        .data_we_o(data_we), .tag_we_o(tag_we), .use_refill_o(use_refill),
        .fill_o(fill), .mark_dirty_o(mark_dirty)
    );

endmodule

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  start_i,             // Request accepted this cycle
    input  logic                  is_write_i,
    input  logic                  hit_i,
    input  dcache_pkg::way_sel_t  hit_way_i,
    input  dcache_pkg::way_sel_t  victim_i,
    input  logic                  victim_dirty_i,
    input  dcache_pkg::tag_t      victim_tag_i,
    input  dcache_pkg::line_t     victim_line_i,
    input  bus_pkg::word_t        req_addr_i,          // Registered request address
    output logic                  mem_req_valid_o,
    output bus_pkg::mem_req_t     mem_req_o,
    input  logic                  mem_req_ready_i,
    input  logic                  mem_rsp_valid_i,
    input  bus_pkg::mem_rsp_t     mem_rsp_i,
    output dcache_pkg::line_t     refill_line_o,
    output logic                  req_ready_o,
    output logic                  rsp_valid_o,
    output dcache_pkg::way_mask_t data_we_o,
    output dcache_pkg::way_mask_t tag_we_o,
    output logic                  use_refill_o,
    output logic                  fill_o,
    output logic                  mark_dirty_o
);

    localparam int unsigned lo_bits = `DC_WORD_OFS_BITS + `DC_BYTE_OFS_BITS;

    typedef enum logic [2:0] {
        st_idle,                                       // Waiting for a request
        st_lookup,                                     // Tags and data out of the RAMs
        st_write_back,                                 // Dirty victim to memory
        st_refill,                                     // Line read from memory
        st_finish                                      // Line written, response sent
    } state_e;

    state_e         state_q, state_d;
    logic           mem_fire;                          // Memory request handshake
    logic           miss;                              // Lookup found nothing
    bus_pkg::word_t line_addr, wb_addr;

    assign mem_fire  = mem_req_valid_o && mem_req_ready_i;
    assign miss      = (state_q == st_lookup) && !hit_i;
    assign line_addr = {req_addr_i[`DC_XLEN-1:lo_bits], {lo_bits{1'b0}}};
    assign wb_addr   = {victim_tag_i, req_addr_i[lo_bits +: `DC_SET_BITS], {lo_bits{1'b0}}};

    // ========================================
    // State sequencing
    // ========================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= st_idle;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            st_idle:
                if (start_i)
                    state_d = st_lookup;
            st_lookup:
                if (hit_i)
                    state_d = st_idle;                 // Hit done in one cycle
                else
                    state_d = victim_dirty_i ? st_write_back : st_refill;
            st_write_back:
                if (mem_fire)
                    state_d = st_refill;               // Write done at acceptance
            st_refill:
                if (mem_rsp_valid_i)
                    state_d = st_finish;
            st_finish:
                state_d = st_idle;
            default:
                state_d = st_idle;
        endcase
    end

    // ========================================
    // Memory request, held until accepted
    // ========================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            mem_req_valid_o <= 1'b0;
        else if (miss)
            mem_req_valid_o <= 1'b1;
        else if (mem_fire && state_q == st_refill)
            mem_req_valid_o <= 1'b0;                   // Refill read taken, wait for data
    end

    always_ff @(posedge clk_i)
    begin
        if (miss && victim_dirty_i)
            mem_req_o <= '{we: 1'b1, addr: wb_addr, data: victim_line_i};
        else if (miss || (state_q == st_write_back && mem_fire))
            mem_req_o <= '{we: 1'b0, addr: line_addr, data: '0}; // Refill read
    end

    // Returned line kept for the finish cycle
    always_ff @(posedge clk_i)
    begin
        if (state_q == st_refill && mem_rsp_valid_i)
            refill_line_o <= mem_rsp_i.data;
    end

    // ========================================
    // RAM, state and response controls
    // ========================================
    always_comb
    begin
        data_we_o = '0;
        tag_we_o  = '0;
        if (state_q == st_lookup && hit_i && is_write_i)
            data_we_o[hit_way_i] = 1'b1;               // Store hit, merged line
        else if (state_q == st_finish)
        begin
            data_we_o[victim_i] = 1'b1;                // New line into the victim way
            tag_we_o[victim_i]  = 1'b1;
        end
    end

    assign req_ready_o  = (state_q == st_idle);
    assign rsp_valid_o  = (state_q == st_lookup && hit_i) || (state_q == st_finish);
    assign use_refill_o = (state_q == st_finish);
    assign fill_o       = (state_q == st_finish);     // Dirty taken from the write flag
    assign mark_dirty_o = (state_q == st_lookup) && hit_i && is_write_i;

endmodule

// File: verilog/word_merge.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

// Word pick and byte-lane merge on one line
module word_merge (
    input  dcache_pkg::line_t     line_i,
    input  dcache_pkg::word_ofs_t word_ofs_i,
    input  bus_pkg::byte_en_t     be_i,
    input  bus_pkg::word_t        wdata_i,
    output bus_pkg::word_t        word_o,
    output dcache_pkg::line_t     line_o
);

    bus_pkg::word_t merged;                            // Addressed word after the store

    // Word 0 sits in the low bits
    assign word_o = line_i[word_ofs_i * `DC_XLEN +: `DC_XLEN];

    // Enabled lanes take store data
    always_comb
    begin
        for (int b = 0; b < `DC_XLEN / 8; b++)
            merged[b*8 +: 8] = be_i[b] ? wdata_i[b*8 +: 8] : word_o[b*8 +: 8];
    end

    // Rest of the line passes unchanged
    always_comb
    begin
        line_o = line_i;
        line_o[word_ofs_i * `DC_XLEN +: `DC_XLEN] = merged;
    end

endmodule

// File: verilog/line_state.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module line_state (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  dcache_pkg::set_idx_t                    set_i,
    output dcache_pkg::way_state_t [`DC_N_WAYS-1:0] state_o,
    output dcache_pkg::way_sel_t                    victim_o,
    input  logic                                    fill_i,
    input  dcache_pkg::way_sel_t                    fill_way_i,
    input  logic                                    fill_dirty_i,
    input  logic                                    mark_dirty_i,
    input  dcache_pkg::way_sel_t                    hit_way_i
);

    dcache_pkg::way_mask_t valid_q [`DC_N_SETS];      // Valid bit per way
    dcache_pkg::way_mask_t dirty_q [`DC_N_SETS];      // Dirty bit per way
    dcache_pkg::way_sel_t  fifo_q  [`DC_N_SETS];      // Next way to replace

    // ========================================
    // Combinational read of the addressed set
    // ========================================
    always_comb
    begin
        for (int w = 0; w < `DC_N_WAYS; w++)
        begin
            state_o[w].valid = valid_q[set_i][w];
            state_o[w].dirty = dirty_q[set_i][w];
        end
    end

    assign victim_o = fifo_q[set_i];                   // Oldest fill in the set

    // ========================================
    // Updates
    // ========================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < `DC_N_SETS; s++)
            begin
                valid_q[s] <= '0;                      // Everything invalid
                dirty_q[s] <= '0;
                fifo_q[s]  <= '0;
            end
        end
        else
        begin
            if (fill_i)
            begin
                valid_q[set_i][fill_way_i] <= 1'b1;
                dirty_q[set_i][fill_way_i] <= fill_dirty_i; // Dirty after a store miss
                fifo_q[set_i]              <= fifo_q[set_i] + 1'b1; // Wraps over the ways
            end
            if (mark_dirty_i)
                dirty_q[set_i][hit_way_i] <= 1'b1;    // Store hit
        end
    end

endmodule

// File: verilog/way_ram.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

// One entry per set, read data registered
module way_ram #(
    parameter type entry_t = logic
) (
    input  logic                 clk_i,
    input  logic                 we_i,
    input  dcache_pkg::set_idx_t addr_i,
    input  entry_t               data_i,
    output entry_t               data_o
);

    entry_t mem [`DC_N_SETS];                          // Storage, no reset

    always_ff @(posedge clk_i)
    begin
        if (we_i)
        begin
            mem[addr_i] <= data_i;
            data_o      <= data_i;                     // Write-first
        end
        else
            data_o <= mem[addr_i];
    end

endmodule

// File: verilog/bus_pkg.sv
`include "dcache_params.svh"

package bus_pkg;

    typedef logic [`DC_XLEN-1:0]   word_t;             // Data word
    typedef logic [`DC_XLEN/8-1:0] byte_en_t;          // One enable per byte lane

    // ========================================
    // Processor side
    // ========================================
    typedef struct packed {
        logic     we;                                  // 1 for store
        byte_en_t be;                                  // Store lanes
        word_t    addr;                                // Byte address
        word_t    wdata;                               // Store data
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;                                  // Load data, valid for reads only
    } cpu_rsp_t;

    // ========================================
    // Memory side, whole lines
    // ========================================
    typedef struct packed {
        logic              we;                         // 1 for write-back
        word_t             addr;                       // Line aligned
        dcache_pkg::line_t data;                       // Write-back payload
    } mem_req_t;

    typedef struct packed {
        dcache_pkg::line_t data;                       // Refill payload
    } mem_rsp_t;

endpackage

// File: verilog/dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

    // ========================================
    // Address fields
    // ========================================
    typedef logic [`DC_TAG_BITS-1:0]      tag_t;      // Upper address bits kept per line
    typedef logic [`DC_SET_BITS-1:0]      set_idx_t;  // Selects one set
    typedef logic [`DC_WORD_OFS_BITS-1:0] word_ofs_t; // Word within a line

    // ========================================
    // Way selection
    // ========================================
    typedef logic [$clog2(`DC_N_WAYS)-1:0] way_sel_t; // Encoded way number
    typedef logic [`DC_N_WAYS-1:0]         way_mask_t; // One bit per way, write enables

    // Line payload, word 0 in the low bits
    typedef logic [`DC_LINE_BITS-1:0] line_t;

    // Per-way status bits
    typedef struct packed {
        logic valid;                                   // Line holds memory data
        logic dirty;                                   // Line differs from memory
    } way_state_t;

endpackage

// File: verilog/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// ========================================
// Cache geometry
// ========================================
`define DC_XLEN          32                            // Core word width
`define DC_LINE_BITS     128                           // Four words per line
`define DC_N_WAYS        4                             // Associativity
`define DC_N_SETS        16                            // Sets per way

// Address field widths, derived from the geometry above
`define DC_BYTE_OFS_BITS $clog2(`DC_XLEN / 8)
`define DC_WORD_OFS_BITS $clog2(`DC_LINE_BITS / `DC_XLEN)
`define DC_SET_BITS      $clog2(`DC_N_SETS)
`define DC_TAG_BITS      (`DC_XLEN - `DC_SET_BITS - `DC_WORD_OFS_BITS - `DC_BYTE_OFS_BITS)

`endif
